// ==== compile.f ====
hw/fir_pkg.sv
hw/fir_tap_cell.sv
hw/fir_sum_drain.sv
hw/fir_wb_front.sv
hw/fir_wb_top.sv
test/fir_tb_checks.sv
test/fir_tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the FIR Wishbone testbench with Verilator, runs it and checks the log

set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  --top-module fir_tb_top \
  -f compile.f \
  --Mdir obj_dir \
  -o fir_sim

./obj_dir/fir_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
  echo "Simulation passed, see sim.log"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== test/fir_tb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the Wishbone FIR peripheral; drives bus traffic,
// models the filter and leaves the checking to fir_tb_checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_tb_top;
  import fir_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_RANDOM = 50;
  localparam int NUM_IDLE   = 6;
  localparam int MAX_IDLE   = 16;
  // Impulse, random, clear, status and bus phases
  localparam int NUM_TXN = 16 + 2 * NUM_RANDOM + NUM_RANDOM / 5 + 5 + 8 + 18 + NUM_IDLE;
  localparam int TIMEOUT_CYCLES = NUM_TXN * 10 + NUM_IDLE * MAX_IDLE + 50;

  logic             clk;
  logic             rst_n;
  wb_req_t          wb_req;
  wb_rsp_t          wb_rsp;
  logic [WB_DW-1:0] exp_dat;
  int               err_total;
  int               n_reads;
  int               n_writes;
  int               seed = 32'h7025_a5e3;

  // Reference model state
  int                         ref_coef [NUM_TAPS] = '{-9, -56, -109, 0, 109, 56, 9};
  logic signed [SAMPLE_W-1:0] hist [NUM_TAPS];
  logic [7:0]                 model_cnt;
  logic                       model_flag;

  fir_wb_top u_fir_wb_top (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  fir_tb_checks u_checks (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .exp_dat   (exp_dat),
    .err_total (err_total)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Truncated sum over the sample history, sign extended to the bus
  function automatic logic [WB_DW-1:0] expected_result();
    longint           acc;
    logic [ACC_W-1:0] trunc;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      acc = acc + longint'(hist[k]) * longint'(ref_coef[k]);
    end
    trunc = acc[ACC_W-1:0];
    return {{(WB_DW - ACC_W){trunc[ACC_W-1]}}, trunc};
  endfunction

  // Request held from one falling edge until the one after ack
  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = adr;
    wb_req.dat = dat;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    @(negedge clk);
    wb_req   = '0;
    n_writes = n_writes + 1;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] exp);
    exp_dat    = exp;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    @(negedge clk);
    while (!wb_rsp.ack) @(negedge clk);
    @(negedge clk);
    wb_req  = '0;
    n_reads = n_reads + 1;
  endtask

  task automatic push_sample(input logic signed [SAMPLE_W-1:0] s);
    wb_write(SAMPLE, WB_DW'(s));
    for (int k = NUM_TAPS - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0]    = s;
    model_cnt  = model_cnt + 8'd1;
    model_flag = 1'b1;
  endtask

  task automatic apply_clear();
    wb_write(CTRL, CMD_CLEAR);
    for (int k = 0; k < NUM_TAPS; k++) begin
      hist[k] = '0;
    end
    model_cnt = '0;
  endtask

  task automatic check_result();
    wb_read(RESULT, expected_result());
    model_flag = 1'b0;
  endtask

  task automatic check_status();
    wb_read(STATUS, {16'h0, model_cnt, 7'h0, model_flag});
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  initial begin
    logic signed [SAMPLE_W-1:0] s;
    int                         n;
    rst_n      = 1'b0;
    wb_req     = '0;
    exp_dat    = '0;
    n_reads    = 0;
    n_writes   = 0;
    model_cnt  = '0;
    model_flag = 1'b0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      hist[k] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Impulse gives the coefficients in tap order
    apply_clear();
    check_status();
    for (int k = 0; k < NUM_TAPS; k++) begin
      push_sample((k == 0) ? 16'sd1 : 16'sd0);
      wb_read(RESULT, WB_DW'(ref_coef[k]));
      model_flag = 1'b0;
    end

    // Random samples with full-scale values mixed in
    for (int i = 0; i < NUM_RANDOM; i++) begin
      s = SAMPLE_W'($random(seed));
      if (i % 10 == 0) s = 16'sh8000;
      if (i == 5) s = 16'sh7fff;
      push_sample(s);
      if (i % 5 == 4) check_status();
      check_result();
    end

    // Clear zeroes the line, the result and the count
    apply_clear();
    check_result();
    check_status();
    push_sample(SAMPLE_W'($random(seed)));
    check_result();

    // Flag set by a write, dropped by a RESULT read
    push_sample(16'sh1234);
    check_status();
    check_result();
    check_status();
    for (int i = 0; i < 3; i++) begin
      push_sample(SAMPLE_W'($random(seed)));
    end
    check_status();

    // Write-only and unmapped addresses read zero
    wb_read(SAMPLE, '0);
    wb_read(CTRL, '0);
    for (int a = 4; a < 16; a++) begin
      wb_read(WB_AW'(a), '0);
    end
    // Writes to RESULT and a NOP command change nothing
    wb_write(RESULT, 32'hdead_beef);
    check_result();
    wb_write(CTRL, CMD_NOP);
    check_result();

    // Idle stretches hold the result
    for (int j = 0; j < NUM_IDLE; j++) begin
      n = 1 + int'($random(seed) & 15);
      idle_cycles(n);
      check_result();
    end

    repeat (2) @(negedge clk);
    $display("Checks finished: %0d errors over %0d reads and %0d writes",
             err_total, n_reads, n_writes);
    if (err_total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== test/fir_tb_checks.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus and read data checker for the FIR testbench; compares
// every read against the expected value driven by the model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_tb_checks (
  input  logic                         clk,
  input  logic                         rst_n,
  input  fir_pkg::wb_req_t             wb_req,
  input  fir_pkg::wb_rsp_t             wb_rsp,
  input  logic [fir_pkg::WB_DW-1:0]    exp_dat,
  output int                           err_total
);
  import fir_pkg::*;

  logic req_valid;

  // One counter per check
  int n_ack_long  = 0;
  int n_ack_cause = 0;
  int n_no_ack    = 0;
  int n_rd_data   = 0;
  int n_dat_zero  = 0;

  assign req_valid = wb_req.cyc && wb_req.stb;
  assign err_total = n_ack_long + n_ack_cause + n_no_ack + n_rd_data + n_dat_zero;

  // Ack lasts exactly one cycle
  c_ack_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack
  ) else begin
    $display("ack stayed high for more than one cycle");
    n_ack_long = n_ack_long + 1;
  end

  // Ack never rises on its own
  c_ack_cause : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(wb_rsp.ack) |-> $past(req_valid)
  ) else begin
    $display("ack rose without a request on cyc and stb");
    n_ack_cause = n_ack_cause + 1;
  end

  // Classic slave answers on the next clock
  c_req_acked : assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_valid && !wb_rsp.ack) |=> wb_rsp.ack
  ) else begin
    $display("request was not acknowledged on the following cycle");
    n_no_ack = n_no_ack + 1;
  end

  // Read data against the model
  c_rd_data : assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb_rsp.ack && !wb_req.we) |-> (wb_rsp.dat == exp_dat)
  ) else begin
    $display("MISMATCH wb_rsp.dat adr 0x%h: got 0x%h expected 0x%h",
             $sampled(wb_req.adr), $sampled(wb_rsp.dat), $sampled(exp_dat));
    n_rd_data = n_rd_data + 1;
  end

  // Bus data is zero outside a read ack
  c_dat_zero : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!wb_rsp.ack || wb_req.we) |-> (wb_rsp.dat == '0)
  ) else begin
    $display("MISMATCH wb_rsp.dat outside read ack: got 0x%h expected 0x%h",
             $sampled(wb_rsp.dat), {WB_DW{1'b0}});
    n_dat_zero = n_dat_zero + 1;
  end

endmodule

// ==== hw/fir_wb_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIR peripheral top; Wishbone front end, tap chain and drain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_wb_top (
  input  logic             clk,
  input  logic             rst_n,
  input  fir_pkg::wb_req_t wb_req,
  output fir_pkg::wb_rsp_t wb_rsp
);
  import fir_pkg::*;

  tap_ctl_t                   ctl;
  logic signed [ACC_W-1:0]    result;
  logic                       result_pulse;
  logic signed [SAMPLE_W-1:0] chain    [NUM_TAPS];
  logic signed [ACC_W-1:0]    products [NUM_TAPS];

  fir_wb_front u_front (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .ctl          (ctl),
    .result       (result),
    .result_pulse (result_pulse)
  );

  // Cell 0 sees the written sample directly
  assign chain[0] = ctl.sample;

  for (genvar k = 0; k < NUM_TAPS; k++) begin : g_tap
    if (k < NUM_TAPS - 1) begin : g_mid
      fir_tap_cell #(.COEF(COEFS[k])) u_cell (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctl     (ctl),
        .tap_in  (chain[k]),
        .tap_out (chain[k+1]),
        .product (products[k])
      );
    end else begin : g_last
      // Oldest sample is not needed further down
      fir_tap_cell #(.COEF(COEFS[k])) u_cell (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctl     (ctl),
        .tap_in  (chain[k]),
        .tap_out (),
        .product (products[k])
      );
    end
  end

  fir_sum_drain u_drain (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctl          (ctl),
    .products     (products),
    .result       (result),
    .result_pulse (result_pulse)
  );

endmodule

// ==== hw/fir_wb_front.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic slave for the FIR; decodes the register map
// and drives the advance and clear pulses to the tap chain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_wb_front (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fir_pkg::wb_req_t                 wb_req,
  output fir_pkg::wb_rsp_t                 wb_rsp,
  output fir_pkg::tap_ctl_t                ctl,
  input  logic signed [fir_pkg::ACC_W-1:0] result,
  input  logic                             result_pulse
);
  import fir_pkg::*;

  logic             ack;
  logic             req_valid;
  fir_reg_e         reg_sel;
  logic             wr_ack;
  logic             rd_ack;
  logic             new_flag;
  logic [7:0]       sample_cnt;
  logic [WB_DW-1:0] rd_data;

  assign req_valid = wb_req.cyc && wb_req.stb;
  assign reg_sel   = fir_reg_e'(wb_req.adr);

  // Request is held until ack, so the ack cycle still sees it
  assign wr_ack = ack && req_valid && wb_req.we;
  assign rd_ack = ack && req_valid && !wb_req.we;

  // Single cycle ack, one per request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req_valid && !ack;
    end
  end

  // Pulses to the tap cells and the drain
  always_comb begin
    ctl.advance = wr_ack && (reg_sel == SAMPLE);
    ctl.clear   = wr_ack && (reg_sel == CTRL) &&
                  (fir_cmd_e'(wb_req.dat) == CMD_CLEAR);
    ctl.sample  = wb_req.dat[SAMPLE_W-1:0];
  end

  // New-result flag, a fresh result beats a clearing read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      new_flag <= 1'b0;
    end else if (result_pulse) begin
      new_flag <= 1'b1;
    end else if (rd_ack && (reg_sel == RESULT)) begin
      new_flag <= 1'b0;
    end
  end

  // Samples since reset or clear, wraps at 256
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sample_cnt <= '0;
    end else if (ctl.clear) begin
      sample_cnt <= '0;
    end else if (ctl.advance) begin
      sample_cnt <= sample_cnt + 8'd1;
    end
  end

  // Read mux; write-only and unmapped addresses read zero
  always_comb begin
    rd_data = '0;
    case (reg_sel)
      RESULT: begin
        rd_data = {{(WB_DW - ACC_W){result[ACC_W-1]}}, result};
      end
      STATUS: begin
        rd_data[0]    = new_flag;
        rd_data[15:8] = sample_cnt;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  always_comb begin
    wb_rsp.ack = ack;
    wb_rsp.dat = rd_ack ? rd_data : '0;
  end

  // Never two acks in a row for one held request
  a_ack_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    ack |=> !ack
  ) else $error("ack held high for two cycles");

  // Ack only answers a request seen on the previous edge
  a_ack_after_req : assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(ack) |-> $past(req_valid)
  ) else $error("ack raised without cyc and stb");

endmodule

// ==== hw/fir_sum_drain.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sums the tap products into the truncated FIR result and
// flags each new capture to the Wishbone front end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_sum_drain (
  input  logic                             clk,
  input  logic                             rst_n,
  input  fir_pkg::tap_ctl_t                ctl,
  input  logic signed [fir_pkg::ACC_W-1:0] products [fir_pkg::NUM_TAPS],
  output logic signed [fir_pkg::ACC_W-1:0] result,
  output logic                             result_pulse
);
  import fir_pkg::*;

  logic signed [ACC_W-1:0] sum;

  // Wraps modulo 2**ACC_W, upper bits simply dropped
  always_comb begin
    sum = '0;
    for (int i = 0; i < NUM_TAPS; i++) begin
      sum = sum + products[i];
    end
  end

  // Capture on the same edge the cells shift
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
    end else if (ctl.clear) begin
      result <= '0;
    end else if (ctl.advance) begin
      result <= sum;
    end
  end

  // One cycle after each capture
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_pulse <= 1'b0;
    end else begin
      result_pulse <= ctl.advance && !ctl.clear;
    end
  end

  // Pulse must trace back to a sample advance
  a_pulse_after_adv : assert property (
    @(posedge clk) disable iff (!rst_n)
    result_pulse |-> $past(ctl.advance)
  ) else $error("result_pulse without a preceding advance");

endmodule

// ==== hw/fir_tap_cell.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One FIR delay stage with its fixed coefficient product;
// chained by a generate loop in the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fir_tap_cell #(
  parameter logic signed [fir_pkg::COEF_W-1:0] COEF = '0
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  fir_pkg::tap_ctl_t                   ctl,
  input  logic signed [fir_pkg::SAMPLE_W-1:0] tap_in,
  output logic signed [fir_pkg::SAMPLE_W-1:0] tap_out,
  output logic signed [fir_pkg::ACC_W-1:0]    product
);
  import fir_pkg::*;

  logic signed [SAMPLE_W-1:0] delay_q;
  logic signed [ACC_W-1:0]    tap_ext;
  logic signed [ACC_W-1:0]    coef_ext;

  // Delay register, clear takes priority
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      delay_q <= '0;
    end else if (ctl.clear) begin
      delay_q <= '0;
    end else if (ctl.advance) begin
      delay_q <= tap_in;
    end
  end

  assign tap_out = delay_q;

  // Sign extend both operands before the multiply
  assign tap_ext  = ACC_W'(tap_in);
  assign coef_ext = ACC_W'(COEF);
  assign product  = tap_ext * coef_ext;

  // Delay line holds between writes
  a_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    !ctl.advance && !ctl.clear |=> $stable(delay_q)
  ) else $error("tap register changed without advance or clear");

endmodule

// ==== hw/fir_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, coefficients, register map and bus types
// for the Wishbone FIR peripheral; imported by every RTL block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package fir_pkg;

  // Datapath widths
  localparam int SAMPLE_W = 16;
  localparam int ACC_W    = 28;
  localparam int COEF_W   = 8;
  localparam int NUM_TAPS = 7;

  // Wishbone widths, word addressed
  localparam int WB_DW = 32;
  localparam int WB_AW = 4;

  // Antisymmetric differentiator, indexed by tap number
  localparam logic signed [COEF_W-1:0] COEFS [NUM_TAPS] = '{
    -8'sd9, -8'sd56, -8'sd109, 8'sd0, 8'sd109, 8'sd56, 8'sd9
  };

  // Register map
  typedef enum logic [WB_AW-1:0] {
    SAMPLE = 4'd0,  // write only
    RESULT = 4'd1,  // read only
    STATUS = 4'd2,  // read only
    CTRL   = 4'd3   // write only
  } fir_reg_e;

  // CTRL write data
  typedef enum logic [WB_DW-1:0] {
    CMD_NOP   = 'd0,
    CMD_CLEAR = 'd1
  } fir_cmd_e;

  // Master request
  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [WB_AW-1:0] adr;
    logic [WB_DW-1:0] dat;
  } wb_req_t;

  // Slave response
  typedef struct packed {
    logic             ack;
    logic [WB_DW-1:0] dat;
  } wb_rsp_t;

  // Broadcast from the front end to the cells and the drain
  typedef struct packed {
    logic                       advance;
    logic                       clear;
    logic signed [SAMPLE_W-1:0] sample;
  } tap_ctl_t;

endpackage
